//--- hdl/c16_defs.svh
// Widths, download indexes and fixed addresses of the C16 memory design, included by all RTL
`ifndef C16_DEFS_SVH
`define C16_DEFS_SVH

////////////////////////////////////////
// Widths

// CPU address space and main RAM
`define C16_RAM_AW 16
// Host download address
`define C16_DL_AW 25

////////////////////////////////////////
// Download slots

`define C16_IDX_PRG 8'd1
`define C16_IDX_CART 8'd2
// 16 KB block number inside a cartridge image
`define C16_CART_BLOCK_AW 24:14

////////////////////////////////////////
// Memory map

// Bank latch lives at FDD0..FDDF
`define C16_IO_BANK_PAGE 12'hFDD
`define C16_KERNAL_PAGE 8'hFC

// BASIC pointers that receive the end of a loaded program
`define C16_PTR_ADDR0 16'h002D
`define C16_PTR_ADDR1 16'h002E
`define C16_PTR_ADDR2 16'h002F
`define C16_PTR_ADDR3 16'h0030
`define C16_PTR_ADDR4 16'h0031
`define C16_PTR_ADDR5 16'h0032
`define C16_PTR_ADDR6 16'h009D
`define C16_PTR_ADDR7 16'h009E

`endif

//--- hdl/c16_map_pkg.sv
// Memory-map types shared by the CPU port and the top level; import where ROM or bank types are used
`include "c16_defs.svh"

package c16_map_pkg;

	////////////////////////////////////////
	// ROM selection

	// Which ROM drives the data bus for the current CPU cycle
	typedef enum logic [2:0] {
		rom_none,
		rom_basic,
		rom_kernal,
		rom_func_low,
		rom_func_high,
		rom_cart_low,
		rom_cart_high
	} rom_src_t;

	////////////////////////////////////////
	// Plus/4 bank latch

	// Field view of the latch nibble
	// High field picks the ROM at C000, low field the ROM at 8000
	typedef struct packed {
		logic [1:0] high;
		logic [1:0] low;
	} bank_fields_t;

	// The latch is written as a raw address nibble and decoded by field
	typedef union packed {
		logic [3:0]   raw;
		bank_fields_t fld;
	} bank_reg_u;

	// Bank selections shared by both halves of the decode
	localparam logic [1:0] bank_sys  = 2'd0;
	localparam logic [1:0] bank_cart = 2'd1;
	localparam logic [1:0] bank_func = 2'd2;

endpackage

//--- hdl/c16_xfer_pkg.sv
// Transfer types for RAM requesters and the program loader; import where they are used
`include "c16_defs.svh"

package c16_xfer_pkg;

	////////////////////////////////////////
	// RAM requesters

	// Owner of a granted RAM access
	typedef enum logic {
		req_cpu,
		req_loader
	} req_id_t;

	////////////////////////////////////////
	// Loader sequencing

	// Header takes the load address, body streams data, fixup writes the pointers
	typedef enum logic [1:0] {
		phase_idle,
		phase_header,
		phase_body,
		phase_fixup
	} load_phase_t;

endpackage

//--- hdl/ram_port_if.sv
// One requester's access to main RAM; the requester side holds the access until granted
`include "c16_defs.svh"

interface ram_port_if;

	// Access presented by the requester
	logic                   req;
	logic                   we;
	logic [`C16_RAM_AW-1:0] addr;
	logic [7:0]             wdata;

	// Answer from the arbiter
	logic                   gnt;
	logic [7:0]             rdata;
	// Pulses one cycle after a granted read
	logic                   rvalid;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata,
		input  rvalid
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

//--- hdl/prg_loader.sv
// Writes a PRG download into main RAM, patches the BASIC pointers, and tracks cartridge halves
`include "c16_defs.svh"

module prg_loader import c16_xfer_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic [7:0]            dl_index_i,
	input  logic                  dl_wr_i,
	input  logic [`C16_DL_AW-1:0] dl_addr_i,
	input  logic [7:0]            dl_data_i,
	output logic                  dl_wait_o,
	output logic                  cart_lo_o,
	output logic                  cart_hi_o,
	ram_port_if.requester         ram
);

	load_phase_t            phase;
	logic                   dl_active_q;
	logic [3:0]             fix_cnt;
	logic [`C16_RAM_AW-1:0] load_addr;
	logic                   req_q;
	logic [`C16_RAM_AW-1:0] addr_q;
	logic [7:0]             data_q;
	logic                   is_prg;
	logic                   is_cart;
	logic                   slot_free;

	// Pointer byte for each fixup step
	function automatic logic [`C16_RAM_AW-1:0] ptr_addr(input logic [2:0] idx);
		case (idx)
			3'd0: ptr_addr = `C16_PTR_ADDR0;
			3'd1: ptr_addr = `C16_PTR_ADDR1;
			3'd2: ptr_addr = `C16_PTR_ADDR2;
			3'd3: ptr_addr = `C16_PTR_ADDR3;
			3'd4: ptr_addr = `C16_PTR_ADDR4;
			3'd5: ptr_addr = `C16_PTR_ADDR5;
			3'd6: ptr_addr = `C16_PTR_ADDR6;
			default: ptr_addr = `C16_PTR_ADDR7;
		endcase
	endfunction

	assign is_prg    = (dl_index_i == `C16_IDX_PRG);
	assign is_cart   = (dl_index_i == `C16_IDX_CART);
	// Next write may go out once the previous one is taken
	assign slot_free = ~req_q | ram.gnt;

	assign ram.req   = req_q;
	assign ram.we    = 1'b1;
	assign ram.addr  = addr_q;
	assign ram.wdata = data_q;

	////////////////////////////////////////
	// PRG sequencing

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase       <= phase_idle;
			dl_active_q <= 1'b0;
			fix_cnt     <= '0;
			req_q       <= 1'b0;
			dl_wait_o   <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;

			if (req_q && ram.gnt) begin
				req_q     <= 1'b0;
				dl_wait_o <= 1'b0;
			end

			case (phase)
				phase_idle, phase_header: begin
					if (dl_active_i && is_prg) begin
						phase <= phase_header;
						// First two bytes are the little-endian load address
						if (dl_wr_i) begin
							if (!dl_addr_i[0]) begin
								load_addr[7:0] <= dl_data_i;
							end else begin
								load_addr[15:8] <= dl_data_i;
								phase           <= phase_body;
							end
						end
					end
				end
				phase_body: begin
					if (dl_wr_i) begin
						req_q     <= 1'b1;
						addr_q    <= load_addr;
						data_q    <= dl_data_i;
						dl_wait_o <= 1'b1;
						load_addr <= load_addr + 1'b1;
					end
				end
				phase_fixup: begin
					if (slot_free) begin
						if (fix_cnt == 4'd8) begin
							phase <= phase_idle;
						end else begin
							req_q   <= 1'b1;
							addr_q  <= ptr_addr(fix_cnt[2:0]);
							// Even steps take the low byte
							data_q  <= fix_cnt[0] ? load_addr[15:8] : load_addr[7:0];
							fix_cnt <= fix_cnt + 1'b1;
						end
					end
				end
				default: phase <= phase_idle;
			endcase

			// End of a PRG download, load_addr now points past the last byte
			if (dl_active_q && !dl_active_i && is_prg) begin
				phase   <= phase_fixup;
				fix_cnt <= '0;
			end
		end
	end

	////////////////////////////////////////
	// Cartridge presence

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_o <= 1'b0;
			cart_hi_o <= 1'b0;
		end else if (dl_active_i && dl_wr_i && is_cart) begin
			if (dl_addr_i[`C16_CART_BLOCK_AW] == 11'd0) cart_lo_o <= 1'b1;
			if (dl_addr_i[`C16_CART_BLOCK_AW] == 11'd1) cart_hi_o <= 1'b1;
		end
	end

endmodule

//--- hdl/cpu_mem_port.sv
// CPU side of the memory system: RAM requests from chip selects, bank latch and ROM source decode
`include "c16_defs.svh"

module cpu_mem_port import c16_map_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_i,
	input  logic [`C16_RAM_AW-1:0] cpu_addr_i,
	input  logic [7:0]             cpu_dout_i,
	input  logic                   cpu_rnw_i,
	input  logic                   cs_ram_n_i,
	input  logic                   cs0_n_i,
	input  logic                   cs1_n_i,
	input  logic                   cs_io_n_i,
	input  logic                   cart_lo_i,
	input  logic                   cart_hi_i,
	output logic [7:0]             cpu_din_o,
	output logic                   cpu_din_valid_o,
	output rom_src_t               rom_src_o,
	ram_port_if.requester          ram
);

	logic                   cs_ram_n_q;
	logic                   cs_io_n_q;
	logic                   ram_fall;
	logic                   io_fall;
	logic                   req_q;
	logic                   we_q;
	logic [`C16_RAM_AW-1:0] addr_q;
	logic [7:0]             wdata_q;
	logic [7:0]             din_q;
	bank_reg_u              bank_q;
	logic                   kern_page;

	assign ram_fall = cs_ram_n_q & ~cs_ram_n_i;
	assign io_fall  = cs_io_n_q & ~cs_io_n_i;

	assign ram.req   = req_q;
	assign ram.we    = we_q;
	assign ram.addr  = addr_q;
	assign ram.wdata = wdata_q;

	////////////////////////////////////////
	// RAM access

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_ram_n_q <= 1'b1;
			cs_io_n_q  <= 1'b1;
			req_q      <= 1'b0;
		end else begin
			cs_ram_n_q <= cs_ram_n_i;
			cs_io_n_q  <= cs_io_n_i;
			if (req_q && ram.gnt) req_q <= 1'b0;
			// One access per chip select cycle
			if (ram_fall) begin
				req_q   <= 1'b1;
				we_q    <= ~cpu_rnw_i;
				addr_q  <= cpu_addr_i;
				wdata_q <= cpu_dout_i;
			end
		end
	end

	// Hold the last read byte between accesses
	always_ff @(posedge clk_sys) begin
		if (ram.rvalid) din_q <= ram.rdata;
	end

	assign cpu_din_o       = ram.rvalid ? ram.rdata : din_q;
	assign cpu_din_valid_o = ram.rvalid;

	////////////////////////////////////////
	// Plus/4 bank latch

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank_q.raw <= '0;
		end else if (model_i && io_fall && !cpu_rnw_i &&
		             cpu_addr_i[`C16_RAM_AW-1:4] == `C16_IO_BANK_PAGE) begin
			bank_q.raw <= cpu_addr_i[3:0];
		end
	end

	////////////////////////////////////////
	// ROM source decode

	assign kern_page = (cpu_addr_i[`C16_RAM_AW-1:8] == `C16_KERNAL_PAGE);

	always_comb begin
		rom_src_o = rom_none;
		if (!cs0_n_i) begin
			case (bank_q.fld.low)
				bank_sys:  rom_src_o = rom_basic;
				bank_cart: rom_src_o = cart_lo_i ? rom_cart_low : rom_none;
				bank_func: rom_src_o = rom_func_low;
				default:   rom_src_o = rom_none;
			endcase
		end else if (!cs1_n_i) begin
			// Page FC always maps the kernal, whatever the bank
			if (kern_page) begin
				rom_src_o = rom_kernal;
			end else begin
				case (bank_q.fld.high)
					bank_sys:  rom_src_o = rom_kernal;
					bank_cart: rom_src_o = cart_hi_i ? rom_cart_high : rom_none;
					bank_func: rom_src_o = rom_func_high;
					default:   rom_src_o = rom_none;
				endcase
			end
		end
	end

endmodule

//--- hdl/ram_arbiter.sv
// Main 64 KB RAM shared by the CPU port and the loader, CPU served first
`include "c16_defs.svh"

module ram_arbiter import c16_xfer_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	ram_port_if.arbiter cpu,
	ram_port_if.arbiter ldr
);

	logic [7:0]             mem [0:(2**`C16_RAM_AW)-1];
	logic                   any_req;
	req_id_t                sel_id;
	logic                   sel_we;
	logic [`C16_RAM_AW-1:0] sel_addr;
	logic [7:0]             sel_wdata;
	logic                   rd_pend;
	req_id_t                rd_id;
	logic [7:0]             rdata_q;

	////////////////////////////////////////
	// Fixed priority grant

	assign any_req = cpu.req | ldr.req;
	assign sel_id  = cpu.req ? req_cpu : req_loader;

	assign cpu.gnt = cpu.req;
	assign ldr.gnt = ldr.req & ~cpu.req;

	always_comb begin
		if (sel_id == req_cpu) begin
			sel_we    = cpu.we;
			sel_addr  = cpu.addr;
			sel_wdata = cpu.wdata;
		end else begin
			sel_we    = ldr.we;
			sel_addr  = ldr.addr;
			sel_wdata = ldr.wdata;
		end
	end

	////////////////////////////////////////
	// Storage

	// Writes land on the grant edge, reads are registered
	always_ff @(posedge clk_sys) begin
		if (any_req) begin
			if (sel_we) begin
				mem[sel_addr] <= sel_wdata;
			end else begin
				rdata_q <= mem[sel_addr];
			end
		end
	end

	// Remember who asked so the read comes back to the right port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_pend <= 1'b0;
			rd_id   <= req_cpu;
		end else begin
			rd_pend <= any_req & ~sel_we;
			if (any_req) rd_id <= sel_id;
		end
	end

	assign cpu.rdata  = rdata_q;
	assign ldr.rdata  = rdata_q;
	assign cpu.rvalid = rd_pend & (rd_id == req_cpu);
	assign ldr.rvalid = rd_pend & (rd_id == req_loader);

endmodule

//--- hdl/c16_mem_top.sv
// Top level of the C16 / Plus/4 memory system: loader, CPU port and RAM arbiter on plain ports
`include "c16_defs.svh"

module c16_mem_top import c16_map_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_i,
	// Host download
	input  logic                   dl_active_i,
	input  logic [7:0]             dl_index_i,
	input  logic                   dl_wr_i,
	input  logic [`C16_DL_AW-1:0]  dl_addr_i,
	input  logic [7:0]             dl_data_i,
	output logic                   dl_wait_o,
	// CPU bus
	input  logic [`C16_RAM_AW-1:0] cpu_addr_i,
	input  logic [7:0]             cpu_dout_i,
	input  logic                   cpu_rnw_i,
	input  logic                   cs_ram_n_i,
	input  logic                   cs0_n_i,
	input  logic                   cs1_n_i,
	input  logic                   cs_io_n_i,
	output logic [7:0]             cpu_din_o,
	output logic                   cpu_din_valid_o,
	output rom_src_t               rom_src_o,
	output logic                   cart_reset_o
);

	logic cart_lo;
	logic cart_hi;

	ram_port_if cpu_ram ();
	ram_port_if ldr_ram ();

	prg_loader u_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.cart_lo_o   (cart_lo),
		.cart_hi_o   (cart_hi),
		.ram         (ldr_ram.requester)
	);

	cpu_mem_port u_cpu_port (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.model_i         (model_i),
		.cpu_addr_i      (cpu_addr_i),
		.cpu_dout_i      (cpu_dout_i),
		.cpu_rnw_i       (cpu_rnw_i),
		.cs_ram_n_i      (cs_ram_n_i),
		.cs0_n_i         (cs0_n_i),
		.cs1_n_i         (cs1_n_i),
		.cs_io_n_i       (cs_io_n_i),
		.cart_lo_i       (cart_lo),
		.cart_hi_i       (cart_hi),
		.cpu_din_o       (cpu_din_o),
		.cpu_din_valid_o (cpu_din_valid_o),
		.rom_src_o       (rom_src_o),
		.ram             (cpu_ram.requester)
	);

	ram_arbiter u_arbiter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu_ram.arbiter),
		.ldr     (ldr_ram.arbiter)
	);

	// Plus/4 holds the CPU in reset while a cartridge image streams in
	assign cart_reset_o = model_i & dl_active_i & (dl_index_i == `C16_IDX_CART);

endmodule

//--- bench/tb_c16_mem.sv
// Self-checking testbench for the C16 memory top level; compile with src.f and run tb_c16_mem
`include "c16_defs.svh"

module tb_c16_mem import c16_map_pkg::*, c16_xfer_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 400;

	logic                   clk_sys;
	logic                   reset;
	logic                   model_i;
	logic                   dl_active_i;
	logic [7:0]             dl_index_i;
	logic                   dl_wr_i;
	logic [`C16_DL_AW-1:0]  dl_addr_i;
	logic [7:0]             dl_data_i;
	logic                   dl_wait_o;
	logic [`C16_RAM_AW-1:0] cpu_addr_i;
	logic [7:0]             cpu_dout_i;
	logic                   cpu_rnw_i;
	logic                   cs_ram_n_i;
	logic                   cs0_n_i;
	logic                   cs1_n_i;
	logic                   cs_io_n_i;
	logic [7:0]             cpu_din_o;
	logic                   cpu_din_valid_o;
	rom_src_t               rom_src_o;
	logic                   cart_reset_o;

	logic [7:0]  ref_mem [0:(2**`C16_RAM_AW)-1];
	logic [15:0] ptr_list [0:7];
	logic [7:0]  prg_bytes [0:39];
	logic [7:0]  cpu_bytes [0:7];
	logic [31:0] lcg_state;
	logic        cart_lo_exp;
	logic        cart_hi_exp;
	int          checks;
	int          errors;
	int          timeouts;

	c16_mem_top UUT (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.model_i         (model_i),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_wait_o       (dl_wait_o),
		.cpu_addr_i      (cpu_addr_i),
		.cpu_dout_i      (cpu_dout_i),
		.cpu_rnw_i       (cpu_rnw_i),
		.cs_ram_n_i      (cs_ram_n_i),
		.cs0_n_i         (cs0_n_i),
		.cs1_n_i         (cs1_n_i),
		.cs_io_n_i       (cs_io_n_i),
		.cpu_din_o       (cpu_din_o),
		.cpu_din_valid_o (cpu_din_valid_o),
		.rom_src_o       (rom_src_o),
		.cart_reset_o    (cart_reset_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Helpers

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// Expected ROM under the bank rule
	// High field is the upper half of the nibble
	function automatic rom_src_t expect_rom(input logic sel0, input logic sel1,
	                                        input logic [7:0] page, input logic [3:0] nib);
		expect_rom = rom_none;
		if (sel0) begin
			case (nib[1:0])
				2'd0: expect_rom = rom_basic;
				2'd1: expect_rom = cart_lo_exp ? rom_cart_low : rom_none;
				2'd2: expect_rom = rom_func_low;
				default: expect_rom = rom_none;
			endcase
		end else if (sel1) begin
			if (page == 8'hFC) begin
				expect_rom = rom_kernal;
			end else begin
				case (nib[3:2])
					2'd0: expect_rom = rom_kernal;
					2'd1: expect_rom = cart_hi_exp ? rom_cart_high : rom_none;
					2'd2: expect_rom = rom_func_high;
					default: expect_rom = rom_none;
				endcase
			end
		end
	endfunction

	task automatic finish_run();
		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
		finish_run();
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#5;
		reset = 1'b0;
	endtask

	////////////////////////////////////////
	// Download port

	task automatic wait_dl_ready();
		int cnt;
		cnt = 0;
		while (dl_wait_o) begin
			@(posedge clk_sys);
			#5;
			cnt++;
			if (cnt >= timeout_cycles) give_up("dl_wait_o to fall");
		end
	endtask

	// One byte held for one cycle once the loader is ready
	task automatic dl_write(input logic [`C16_DL_AW-1:0] addr, input logic [7:0] data);
		wait_dl_ready();
		dl_wr_i   = 1'b1;
		dl_addr_i = addr;
		dl_data_i = data;
		@(posedge clk_sys);
		#5;
		dl_wr_i = 1'b0;
	endtask

	task automatic load_prg(input logic [15:0] load_addr, input int count);
		logic [`C16_DL_AW-1:0] offs;
		logic [15:0]           end_addr;
		int                    i;
		int                    cnt;
		dl_index_i  = `C16_IDX_PRG;
		dl_active_i = 1'b1;
		dl_write('0, load_addr[7:0]);
		dl_write(25'd1, load_addr[15:8]);
		offs = 25'd2;
		for (i = 0; i < count; i++) begin
			dl_write(offs, prg_bytes[i]);
			ref_mem[load_addr + 16'(i)] = prg_bytes[i];
			offs = offs + 1'b1;
		end
		wait_dl_ready();
		dl_active_i = 1'b0;
		@(posedge clk_sys);
		#5;
		// Pointer fixup runs until the loader goes idle again
		cnt = 0;
		while (UUT.u_loader.phase != phase_idle) begin
			@(posedge clk_sys);
			#5;
			cnt++;
			if (cnt >= timeout_cycles) give_up("the pointer fixup to finish");
		end
		end_addr = load_addr + 16'(count);
		for (i = 0; i < 8; i++) ref_mem[ptr_list[i]] = i[0] ? end_addr[15:8] : end_addr[7:0];
	endtask

	////////////////////////////////////////
	// CPU bus

	task automatic cpu_access(input logic [15:0] addr, input logic rnw,
	                          input logic [7:0] wdata, output logic [7:0] rdata);
		int   cnt;
		logic done;
		cpu_addr_i = addr;
		cpu_rnw_i  = rnw;
		cpu_dout_i = wdata;
		cs_ram_n_i = 1'b0;
		cnt  = 0;
		done = 1'b0;
		// Reads end on valid data and writes once the request is taken
		while (!done) begin
			@(posedge clk_sys);
			#5;
			cnt++;
			done = rnw ? cpu_din_valid_o : !UUT.cpu_ram.req;
			if (!done && cnt >= timeout_cycles) give_up("the CPU access to complete");
		end
		rdata      = cpu_din_o;
		cs_ram_n_i = 1'b1;
		cpu_rnw_i  = 1'b1;
		if (!rnw) ref_mem[addr] = wdata;
		@(posedge clk_sys);
		#5;
	endtask

	task automatic read_check(input logic [15:0] addr);
		logic [7:0] rd;
		cpu_access(addr, 1'b1, 8'h00, rd);
		check_value($sformatf("cpu_din_o @%h", addr), rd, ref_mem[addr]);
	endtask

	task automatic write_bank(input logic [3:0] nib);
		cpu_addr_i = {`C16_IO_BANK_PAGE, nib};
		cpu_rnw_i  = 1'b0;
		cs_io_n_i  = 1'b0;
		@(posedge clk_sys);
		#5;
		cs_io_n_i = 1'b1;
		cpu_rnw_i = 1'b1;
		@(posedge clk_sys);
		#5;
	endtask

	// ROM at 8000 under cs0 and then C000 and FC00 under cs1
	task automatic check_decode(input logic [3:0] nib);
		cpu_addr_i = 16'h8000;
		cs0_n_i    = 1'b0;
		@(negedge clk_sys);
		check_value("rom_src_o", rom_src_o, expect_rom(1'b1, 1'b0, 8'h80, nib));
		@(posedge clk_sys);
		#5;
		cs0_n_i    = 1'b1;
		cs1_n_i    = 1'b0;
		cpu_addr_i = 16'hC000;
		@(negedge clk_sys);
		check_value("rom_src_o", rom_src_o, expect_rom(1'b0, 1'b1, 8'hC0, nib));
		@(posedge clk_sys);
		#5;
		cpu_addr_i = {`C16_KERNAL_PAGE, 8'h00};
		@(negedge clk_sys);
		check_value("rom_src_o", rom_src_o, expect_rom(1'b0, 1'b1, `C16_KERNAL_PAGE, nib));
		@(posedge clk_sys);
		#5;
		cs1_n_i = 1'b1;
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		int         i;
		int         j;
		logic [7:0] rd;
		reset       = 1'b1;
		model_i     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = 8'd0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = 8'd0;
		cpu_addr_i  = 16'h0000;
		cpu_dout_i  = 8'd0;
		cpu_rnw_i   = 1'b1;
		cs_ram_n_i  = 1'b1;
		cs0_n_i     = 1'b1;
		cs1_n_i     = 1'b1;
		cs_io_n_i   = 1'b1;
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		cart_lo_exp = 1'b0;
		cart_hi_exp = 1'b0;
		lcg_state   = 32'h672d;
		ptr_list    = '{`C16_PTR_ADDR0, `C16_PTR_ADDR1, `C16_PTR_ADDR2, `C16_PTR_ADDR3,
		                `C16_PTR_ADDR4, `C16_PTR_ADDR5, `C16_PTR_ADDR6, `C16_PTR_ADDR7};
		for (i = 0; i < 40; i++) prg_bytes[i] = next_random();
		for (i = 0; i < 8; i++) cpu_bytes[i] = next_random();

		apply_reset();
		check_value("dl_wait_o", dl_wait_o, 1'b0);
		check_value("cpu_din_valid_o", cpu_din_valid_o, 1'b0);
		check_value("cart_reset_o", cart_reset_o, 1'b0);

		// PRG download with CPU writes competing for the RAM
		fork
			load_prg(16'h1001, 40);
			begin
				repeat (6) @(posedge clk_sys);
				#5;
				for (j = 0; j < 8; j++) cpu_access(16'h4000 + 16'(j), 1'b0, cpu_bytes[j], rd);
			end
		join

		for (i = 0; i < 40; i++) read_check(16'h1001 + 16'(i));
		for (i = 0; i < 8; i++) read_check(ptr_list[i]);
		for (i = 0; i < 8; i++) read_check(16'h4000 + 16'(i));

		// Plus/4 bank decode over every nibble
		model_i = 1'b1;
		for (i = 0; i < 16; i++) begin
			write_bank(4'(i));
			check_decode(4'(i));
		end

		// Plain C16 ignores the latch
		apply_reset();
		model_i = 1'b0;
		write_bank(4'h5);
		check_decode(4'h0);

		// Cartridge image with the low half first and the high half after it
		model_i = 1'b1;
		write_bank(4'h5);
		dl_index_i  = `C16_IDX_CART;
		dl_active_i = 1'b1;
		dl_write(25'h0000000, 8'hA5);
		check_value("cart_reset_o", cart_reset_o, 1'b1);
		cart_lo_exp = 1'b1;
		check_decode(4'h5);
		dl_write(25'h0004000, 8'h5A);
		check_value("cart_reset_o", cart_reset_o, 1'b1);
		dl_active_i = 1'b0;
		@(posedge clk_sys);
		#5;
		check_value("cart_reset_o", cart_reset_o, 1'b0);
		cart_hi_exp = 1'b1;
		check_decode(4'h5);

		apply_reset();
		cart_lo_exp = 1'b0;
		cart_hi_exp = 1'b0;
		write_bank(4'h5);
		check_decode(4'h5);

		finish_run();
	end

endmodule

//--- src.f
+incdir+hdl
hdl/c16_map_pkg.sv
hdl/c16_xfer_pkg.sv
hdl/ram_port_if.sv
hdl/prg_loader.sv
hdl/cpu_mem_port.sv
hdl/ram_arbiter.sv
hdl/c16_mem_top.sv
bench/tb_c16_mem.sv

//--- Bender.yml
package:
  name: c16_mem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/c16_map_pkg.sv
      - hdl/c16_xfer_pkg.sv
      - hdl/ram_port_if.sv
      - hdl/prg_loader.sv
      - hdl/cpu_mem_port.sv
      - hdl/ram_arbiter.sv
      - hdl/c16_mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_c16_mem.sv
